// File: compile.f
source/tile_pkg.sv
source/tile_bus_decode.sv
source/tile_ctrl_regs.sv
source/tile_sram.sv
source/tile_bootrom.sv
source/compute_tile_top.sv
sim/tb_compute_tile.sv

// File: sim/tile_stimulus.txt
// Columns, all hex: op (1 write, 0 read), address, write data, byte select,
// err (1 expects err, 0 expects ack), expected read data (reads with ack only)
// Register block after reset
0 E0000000 00000000 F 0 00000001
0 E0000004 00000000 F 0 00000000
0 E0000008 00000000 F 0 00000003
// SRAM byte lanes and aliasing
1 00000010 11223344 F 0 00000000
0 00000010 00000000 F 0 11223344
1 00000010 AABBCCDD 5 0 00000000
0 00000010 00000000 F 0 11BB33DD
1 00000010 99887766 8 0 00000000
0 0ABC0010 00000000 F 0 99BB33DD
1 00000414 CAFEF00D F 0 00000000
0 00000014 00000000 F 0 CAFEF00D
// Boot ROM, write and unmapped region
0 F0000000 00000000 F 0 18200000
0 F0000004 00000000 F 0 A82103FC
0 F000001C 00000000 F 0 15000000
0 F0000020 00000000 F 0 18200000
1 F0000008 12345678 F 1 00000000
0 50000000 00000000 F 1 00000000
1 5000000C 00000000 F 1 00000000
// SCRATCH lanes, ID write ignored
1 E0000004 DEADBEEF F 0 00000000
1 E0000004 00001200 2 0 00000000
0 E0000004 00000000 F 0 DEAD12EF
1 E0000008 FFFFFFFF F 0 00000000
0 E0000008 00000000 F 0 00000003
// SRAM write protect
1 E0000000 00000003 1 0 00000000
0 E0000000 00000000 F 0 00000003
1 00000010 00000000 F 1 00000000
0 00000010 00000000 F 0 99BB33DD
1 E0000000 00000001 1 0 00000000
1 00000010 01020304 3 0 00000000
0 00000010 00000000 F 0 99BB0304
// ROM disable and enable
1 E0000000 00000000 1 0 00000000
0 F0000004 00000000 F 1 00000000
1 E0000000 00000001 1 0 00000000
0 F0000004 00000000 F 0 A82103FC

// File: sim/tb_compute_tile.sv
//####################
// Testbench for compute_tile_top, run from the project root
// Transfers and expected responses come from sim/tile_stimulus.txt
// Expected data there assumes MEM_WORDS 256 and TILE_ID 3
//####################
`timescale 1ns/10ps

module tb_compute_tile;

   import tile_pkg::*;

   localparam int      MEM_WORDS = 256;
   localparam wb_dat_t TILE_ID   = 32'h0000_0003;

   // One line of the stimulus file
   typedef struct packed {
      logic    we;
      wb_adr_t adr;
      wb_dat_t dat;
      wb_sel_t sel;
      logic    exp_err;
      wb_dat_t exp_dat;
   } stim_t;

   logic        clk;
   logic        rst_n_i;
   wb_req_t     bus_req;
   wb_rsp_t     bus_rsp;
   stim_t       stim_q[$];
   int          value_errors;
   int          other_errors;
   int unsigned cycle_cnt;
   int unsigned cycle_limit;   // Zero until the stimulus is loaded

   compute_tile_top #(
      .MEM_WORDS (MEM_WORDS),
      .TILE_ID   (TILE_ID)
   ) compute_tile_top_i (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .bus_req_i (bus_req),
      .bus_rsp_o (bus_rsp)
   );

   always #2 clk = ~clk;   // 4 ns period

   // Watchdog
   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
         $display("Timeout: run stopped after %0d cycles before all transfers ended", cycle_cnt);
         $display("TESTBENCH FAILED");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("[FAIL] %s: got %h, expected %h", name, actual, expected);
         value_errors++;
      end
   endtask

   task automatic load_stimulus();
      int          fd;
      int          n;
      string       line;
      logic [31:0] f_op;
      logic [31:0] f_adr;
      logic [31:0] f_dat;
      logic [31:0] f_sel;
      logic [31:0] f_err;
      logic [31:0] f_exp;
      stim_t       s;
      fd = $fopen("sim/tile_stimulus.txt", "r");
      if (fd == 0) begin
         $display("Could not open the stimulus file sim/tile_stimulus.txt");
         other_errors++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_adr, f_dat, f_sel, f_err, f_exp);
            if (n == 6) begin   // Comment and blank lines fall through
               s.we      = f_op[0];
               s.adr     = f_adr;
               s.dat     = f_dat;
               s.sel     = f_sel[3:0];
               s.exp_err = f_err[0];
               s.exp_dat = f_exp;
               stim_q.push_back(s);
            end
         end
         $fclose(fd);
         if (stim_q.size() == 0) begin
            $display("The stimulus file holds no transfers");
            other_errors++;
         end
      end
   endtask

   // Called on a falling edge where no response may be pending
   task automatic check_idle(input string where);
      if (bus_rsp.ack !== 1'b0 || bus_rsp.err !== 1'b0) begin
         $display("Response seen %s while no transfer was in flight", where);
         other_errors++;
      end
   endtask

   task automatic run_transfer(input stim_t s, input int num);
      int    cycles;
      string tag;
      tag = $sformatf("#%0d adr %h", num, s.adr);
      bus_req.adr = s.adr;
      bus_req.dat = s.dat;
      bus_req.sel = s.sel;
      bus_req.we  = s.we;
      bus_req.stb = 1'b1;
      cycles      = 0;
      do begin
         @(negedge clk);
         cycles++;
      end while (bus_rsp.ack !== 1'b1 && bus_rsp.err !== 1'b1);
      if (bus_rsp.ack === 1'b1 && bus_rsp.err === 1'b1) begin
         $display("Transfer %s raised ack and err together", tag);
         other_errors++;
      end
      check_value({"latency ", tag}, cycles, 1);
      check_value({"bus_rsp_o.ack ", tag}, bus_rsp.ack, !s.exp_err);
      check_value({"bus_rsp_o.err ", tag}, bus_rsp.err, s.exp_err);
      if (!s.we && !s.exp_err) begin
         check_value({"bus_rsp_o.dat ", tag}, bus_rsp.dat, s.exp_dat);
      end
      @(negedge clk);
      check_idle({"a cycle after transfer ", tag});   // Response lasts one cycle
      bus_req = '0;
   endtask

   initial begin
      int unsigned seed_ret;
      int unsigned gap;
      clk          = 1'b0;
      rst_n_i      = 1'b0;
      bus_req      = '0;
      value_errors = 0;
      other_errors = 0;
      cycle_cnt    = 0;
      cycle_limit  = 0;
      seed_ret     = $urandom(32'hbf99);
      load_stimulus();
      cycle_limit = stim_q.size() * 6 + 50;
      repeat (3) @(negedge clk);
      rst_n_i = 1'b1;
      @(negedge clk);
      check_value("bus_rsp_o.ack after reset", bus_rsp.ack, 1'b0);
      check_value("bus_rsp_o.err after reset", bus_rsp.err, 1'b0);
      foreach (stim_q[i]) begin
         run_transfer(stim_q[i], i);
         gap = 1 + ($urandom % 3);   // Idle cycles before the next request
         repeat (gap) begin
            @(negedge clk);
            check_idle("in an idle gap");
         end
      end
      $display("Summary: %0d transfers, %0d value errors, %0d other errors",
               stim_q.size(), value_errors, other_errors);
      if (value_errors == 0 && other_errors == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

// File: source/compute_tile_top.sv
//####################
// Compute tile with one external bus master port
// Single transfers only, the response follows the sampled stb by one cycle
// Regions 0x0 SRAM, 0xE control registers, 0xF boot ROM, all others err
//####################
`timescale 1ns/10ps

module compute_tile_top #(
   parameter int                MEM_WORDS = 256,
   parameter tile_pkg::wb_dat_t TILE_ID   = 32'h0000_0003
) (
   input  logic              clk,
   input  logic              rst_n_i,
   input  tile_pkg::wb_req_t bus_req_i,
   output tile_pkg::wb_rsp_t bus_rsp_o
);

   import tile_pkg::*;

   wb_req_t mem_req;
   wb_req_t ctrl_req;
   wb_req_t rom_req;
   wb_rsp_t mem_rsp;
   wb_rsp_t ctrl_rsp;
   wb_rsp_t rom_rsp;
   logic    rom_en;   // From CTRL bit 0
   logic    mem_wp;   // From CTRL bit 1

   tile_bus_decode u_decode (
      .clk        (clk),
      .rst_n_i    (rst_n_i),
      .req_i      (bus_req_i),
      .rom_en_i   (rom_en),
      .mem_wp_i   (mem_wp),
      .mem_req_o  (mem_req),
      .ctrl_req_o (ctrl_req),
      .rom_req_o  (rom_req),
      .mem_rsp_i  (mem_rsp),
      .ctrl_rsp_i (ctrl_rsp),
      .rom_rsp_i  (rom_rsp),
      .rsp_o      (bus_rsp_o)
   );

   tile_ctrl_regs #(
      .TILE_ID (TILE_ID)
   ) u_ctrl_regs (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .req_i    (ctrl_req),
      .rsp_o    (ctrl_rsp),
      .rom_en_o (rom_en),
      .mem_wp_o (mem_wp)
   );

   tile_sram #(
      .MEM_WORDS (MEM_WORDS)
   ) u_sram (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (mem_req),
      .rsp_o   (mem_rsp)
   );

   tile_bootrom u_bootrom (
      .clk     (clk),
      .rst_n_i (rst_n_i),
      .req_i   (rom_req),
      .rsp_o   (rom_rsp)
   );

endmodule

// File: source/tile_bootrom.sv
//####################
// Boot ROM holding BOOT_IMAGE, read only
// Word index wraps modulo BOOT_WORDS
//####################
`timescale 1ns/10ps

module tile_bootrom (
   input  logic              clk,
   input  logic              rst_n_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);

   import tile_pkg::*;

   localparam int ROM_IDX_W = $clog2(BOOT_WORDS);

   logic [ROM_IDX_W-1:0] idx;
   logic                 access;
   logic                 ack_q;
   wb_dat_t              rd_q;

   assign idx    = req_i.adr[ROM_IDX_W+1:2];
   assign access = req_i.stb & ~ack_q;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access && !req_i.we) begin
         rd_q <= BOOT_IMAGE[idx];   // Writes never reach here past the decoder
      end
   end

   assign rsp_o = wb_rsp_t'{ack: ack_q, err: 1'b0, dat: rd_q};

endmodule

// File: source/tile_sram.sv
//####################
// Single-port local data memory, MEM_WORDS a power of two and at least 2
// Address bits above the depth alias, contents are undefined after reset
//####################
`timescale 1ns/10ps

module tile_sram #(
   parameter int MEM_WORDS = 256
) (
   input  logic              clk,
   input  logic              rst_n_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o
);

   import tile_pkg::*;

   localparam int IDX_W = $clog2(MEM_WORDS);

   wb_dat_t          mem [MEM_WORDS];
   logic [IDX_W-1:0] idx;
   logic             access;
   logic             ack_q;
   wb_dat_t          rd_q;

   assign idx    = req_i.adr[IDX_W+1:2];   // Word index, byte offset dropped
   assign access = req_i.stb & ~ack_q;

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_q <= 1'b0;
      end else begin
         ack_q <= access;
      end
   end

   // Byte-lane write enables
   always_ff @(posedge clk) begin
      if (access) begin
         if (req_i.we) begin
            for (int b = 0; b < $bits(wb_sel_t); b++) begin
               if (req_i.sel[b]) mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
         end else begin
            rd_q <= mem[idx];
         end
      end
   end

   assign rsp_o = wb_rsp_t'{ack: ack_q, err: 1'b0, dat: rd_q};

endmodule

// File: source/tile_ctrl_regs.sv
//####################
// Tile control registers, decoded on adr[7:2] only
// The block aliases every 256 bytes inside its region
//####################
`timescale 1ns/10ps

module tile_ctrl_regs #(
   parameter tile_pkg::wb_dat_t TILE_ID = 32'h0000_0003
) (
   input  logic              clk,
   input  logic              rst_n_i,
   input  tile_pkg::wb_req_t req_i,
   output tile_pkg::wb_rsp_t rsp_o,
   output logic              rom_en_o,
   output logic              mem_wp_o
);

   import tile_pkg::*;

   logic [7:0] ofs;
   logic       access;
   logic       ack_q;
   logic       rom_en_q;
   logic       mem_wp_q;
   wb_dat_t    scratch_q;
   wb_dat_t    rd_data;
   wb_dat_t    rd_q;

   assign ofs    = {req_i.adr[7:2], 2'b00};
   assign access = req_i.stb & ~ack_q;   // Ignore stb still high in the ack cycle

   always_comb begin
      case (ofs)
         CTRL_OFS_CTRL:    rd_data = {30'b0, mem_wp_q, rom_en_q};
         CTRL_OFS_SCRATCH: rd_data = scratch_q;
         CTRL_OFS_ID:      rd_data = TILE_ID;
         default:          rd_data = '0;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         ack_q     <= 1'b0;
         rom_en_q  <= 1'b1;   // Boot from ROM out of reset
         mem_wp_q  <= 1'b0;
         scratch_q <= '0;
      end else begin
         ack_q <= access;
         if (access && req_i.we) begin
            if (ofs == CTRL_OFS_CTRL && req_i.sel[0]) begin
               rom_en_q <= req_i.dat[0];
               mem_wp_q <= req_i.dat[1];
            end
            if (ofs == CTRL_OFS_SCRATCH) begin
               for (int b = 0; b < $bits(wb_sel_t); b++) begin
                  if (req_i.sel[b]) scratch_q[8*b +: 8] <= req_i.dat[8*b +: 8];
               end
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access && !req_i.we) rd_q <= rd_data;
   end

   assign rsp_o    = wb_rsp_t'{ack: ack_q, err: 1'b0, dat: rd_q};
   assign rom_en_o = rom_en_q;
   assign mem_wp_o = mem_wp_q;

endmodule

// File: source/tile_bus_decode.sv
//####################
// Address decoder of the tile bus, one transfer in flight
// Unmapped regions, ROM writes, disabled ROM and protected SRAM writes get err
//####################
`timescale 1ns/10ps

module tile_bus_decode (
   input  logic              clk,
   input  logic              rst_n_i,
   input  tile_pkg::wb_req_t req_i,
   input  logic              rom_en_i,
   input  logic              mem_wp_i,
   output tile_pkg::wb_req_t mem_req_o,
   output tile_pkg::wb_req_t ctrl_req_o,
   output tile_pkg::wb_req_t rom_req_o,
   input  tile_pkg::wb_rsp_t mem_rsp_i,
   input  tile_pkg::wb_rsp_t ctrl_rsp_i,
   input  tile_pkg::wb_rsp_t rom_rsp_i,
   output tile_pkg::wb_rsp_t rsp_o
);

   import tile_pkg::*;

   region_t region;
   logic    sel_mem;
   logic    sel_ctrl;
   logic    sel_rom;
   logic    allowed;
   logic    err_q;
   wb_rsp_t slave_rsp;

   assign region   = req_i.adr[31:28];
   assign sel_mem  = (region == REGION_MEM);
   assign sel_ctrl = (region == REGION_CTRL);
   assign sel_rom  = (region == REGION_ROM);

   // Unmapped regions fall out as not allowed
   assign allowed = (sel_mem & ~(req_i.we & mem_wp_i))
                  | sel_ctrl
                  | (sel_rom & rom_en_i & ~req_i.we);

   always_comb begin
      mem_req_o      = req_i;   // adr, dat, sel and we are shared
      ctrl_req_o     = req_i;
      rom_req_o      = req_i;
      mem_req_o.stb  = req_i.stb & sel_mem & allowed;
      ctrl_req_o.stb = req_i.stb & sel_ctrl & allowed;
      rom_req_o.stb  = req_i.stb & sel_rom & allowed;
   end

   // Rejected access answered here with the same one-cycle latency as a slave
   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         err_q <= 1'b0;
      end else begin
         err_q <= req_i.stb & ~allowed & ~err_q;   // One pulse per held request
      end
   end

   always_comb begin
      case (region)
         REGION_MEM:  slave_rsp = mem_rsp_i;
         REGION_CTRL: slave_rsp = ctrl_rsp_i;
         REGION_ROM:  slave_rsp = rom_rsp_i;
         default:     slave_rsp = '0;
      endcase
   end

   // Selected slave got no stb on an error, so its ack is low here
   assign rsp_o = err_q ? wb_rsp_t'{ack: 1'b0, err: 1'b1, dat: '0} : slave_rsp;

endmodule

// File: source/tile_pkg.sv
//####################
// Bus types, address map and boot image of the compute tile
// The region is the top address nibble, and every transfer is a single 32-bit word
// BOOT_WORDS must stay a power of two so the ROM index wraps
//####################
package tile_pkg;

   typedef logic [31:0] wb_adr_t;   // Byte address
   typedef logic [31:0] wb_dat_t;   // Data word
   typedef logic [3:0]  wb_sel_t;   // Bit n enables byte lane n
   typedef logic [3:0]  region_t;   // adr[31:28]

   // cyc and stb are merged into stb since the tile has one master
   typedef struct packed {
      wb_adr_t adr;
      wb_dat_t dat;
      wb_sel_t sel;
      logic    we;
      logic    stb;
   } wb_req_t;

   typedef struct packed {
      logic    ack;
      logic    err;
      wb_dat_t dat;
   } wb_rsp_t;

   localparam region_t REGION_MEM  = 4'h0;   // Local data memory
   localparam region_t REGION_CTRL = 4'hE;   // Tile control registers
   localparam region_t REGION_ROM  = 4'hF;   // Boot ROM

   localparam logic [7:0] CTRL_OFS_CTRL    = 8'h00;
   localparam logic [7:0] CTRL_OFS_SCRATCH = 8'h04;
   localparam logic [7:0] CTRL_OFS_ID      = 8'h08;

   localparam int BOOT_WORDS = 8;

   // Minimal start-up sequence that loads a stack pointer and jumps to SRAM
   localparam wb_dat_t BOOT_IMAGE [BOOT_WORDS] = '{
      32'h1820_0000,   // Load upper stack pointer
      32'hA821_03FC,   // Or in lower stack pointer
      32'h1860_0000,   // Entry address upper half
      32'hA863_0100,   // Entry address lower half
      32'h4400_1800,   // Jump to entry
      32'h1500_0000,   // Delay slot nop
      32'h03FF_FFFF,   // Spin if entry returns
      32'h1500_0000
   };

endpackage
